/* hdl/wire_pkg.sv */
package wire_pkg;

  // ----------------------------------------------------------
  // Flit format
  // ----------------------------------------------------------

  // Header view of a flit payload
  // The tag sits in the low byte and the expected length in the next byte
  typedef struct packed {
    logic [15:0] rsvd;
    logic [7:0]  len;
    logic [7:0]  tag;
  } flit_hdr_t;

  // The same 32 bits are read as a header or as a data word
  // The kind bit of the flit decides which view applies
  typedef union packed {
    flit_hdr_t   hdr;
    logic [31:0] word;
  } flit_payload_u;

  // One flit on the wire is 33 bits wide
  typedef struct packed {
    logic          kind;
    flit_payload_u payload;
  } flit_t;

  localparam logic FLIT_DATA = 1'b0;
  localparam logic FLIT_HDR  = 1'b1;

  // ----------------------------------------------------------
  // Host bus
  // ----------------------------------------------------------

  // Wishbone classic request from the host master
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // Wishbone classic response from the slave
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Word addresses of the register map
  localparam logic [2:0] ADR_TX_HDR   = 3'd0;
  localparam logic [2:0] ADR_TX_DATA  = 3'd1;
  localparam logic [2:0] ADR_RX_DATA  = 3'd2;
  localparam logic [2:0] ADR_STATUS   = 3'd3;
  localparam logic [2:0] ADR_CHECKSUM = 3'd4;

  // Depth of the receive queue
  localparam int RXQ_DEPTH = 4;

endpackage

/* hdl/delay_valid_next.sv */
module delay_valid_next #(
  parameter int WIDTH      = 1,
  parameter int NUM_STAGES = 0
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid_next,
  input  logic [WIDTH-1:0] in,
  output logic             out_valid_next,
  output logic [WIDTH-1:0] out
);

  // Element 0 is the input and element NUM_STAGES is the output
  // With no stages the input goes straight to the output
  logic             stage_valid_next [NUM_STAGES+1];
  logic [WIDTH-1:0] stage_data       [NUM_STAGES+1];

  assign stage_valid_next[0] = in_valid_next;
  assign stage_data[0]       = in;

  // ----------------------------------------------------------
  // Pipeline stages
  // ----------------------------------------------------------
  for (genvar i = 1; i <= NUM_STAGES; i++) begin : gen_stage
    // The valid-next bits form a plain shift register that is cleared on reset
    always_ff @(posedge clk) begin
      if (reset) begin
        stage_valid_next[i] <= 1'b0;
      end else begin
        stage_valid_next[i] <= stage_valid_next[i-1];
      end
    end

    // Valid-next of stage i plays the role of valid for stage i-1
    // So the data moves forward only in cycles that carry a real flit
    always_ff @(posedge clk) begin
      if (stage_valid_next[i]) begin
        stage_data[i] <= stage_data[i-1];
      end
    end
  end

  assign out_valid_next = stage_valid_next[NUM_STAGES];
  assign out            = stage_data[NUM_STAGES];

endmodule

/* hdl/flit_launcher.sv */
module flit_launcher (
  input  logic            clk,
  input  logic            reset,
  input  logic            launch,
  input  wire_pkg::flit_t launch_flit,
  output logic            wire_valid_next,
  output wire_pkg::flit_t wire_flit
);

  import wire_pkg::*;

  // Load enable of the flit register
  logic   load_flit;
  // Flit held on the wire between launches
  flit_t  flit_q;

  // ----------------------------------------------------------
  // Valid-next
  // ----------------------------------------------------------

  // The launch pulse is already one cycle ahead of the data
  // It goes onto the wire as valid-next without a register
  assign wire_valid_next = launch;

  // ----------------------------------------------------------
  // Flit register
  // ----------------------------------------------------------

  // The register holds its value while reset is applied
  assign load_flit = launch && !reset;

  // Data follows valid-next by one cycle
  // Between launches the wire keeps its last value and does not toggle
  always_ff @(posedge clk) begin
    if (load_flit) begin
      flit_q <= launch_flit;
    end
  end

  assign wire_flit = flit_q;

endmodule

/* hdl/flit_receiver.sv */
module flit_receiver (
  input  logic            clk,
  input  logic            reset,
  input  logic            wire_valid_next,
  input  wire_pkg::flit_t wire_flit,
  input  logic            pop,
  output logic [31:0]     rx_word,
  output logic [2:0]      rx_level,
  output logic [7:0]      pkt_tag,
  output logic [7:0]      pkt_len,
  output logic [7:0]      pkt_count,
  output logic [31:0]     pkt_checksum,
  output logic            overflow
);

  import wire_pkg::*;

  localparam int PTR_W = $clog2(RXQ_DEPTH);

  logic             rx_valid;
  logic             is_hdr;
  logic             is_data;
  logic             q_full;
  logic             q_push;
  logic             q_pop;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [31:0]      q_mem [RXQ_DEPTH];

  // Valid-next registered once lines up with the flit on the wire
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= wire_valid_next;
    end
  end

  assign is_hdr  = rx_valid && (wire_flit.kind == FLIT_HDR);
  assign is_data = rx_valid && (wire_flit.kind == FLIT_DATA);

  // ----------------------------------------------------------
  // Packet state
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pkt_tag      <= '0;
      pkt_len      <= '0;
      pkt_count    <= '0;
      pkt_checksum <= '0;
      overflow     <= 1'b0;
    end else if (is_hdr) begin
      // A header starts a new packet
      pkt_tag      <= wire_flit.payload.hdr.tag;
      pkt_len      <= wire_flit.payload.hdr.len;
      pkt_count    <= '0;
      pkt_checksum <= '0;
      overflow     <= 1'b0;
    end else if (is_data) begin
      // Dropped words still count toward the packet
      pkt_count    <= pkt_count + 8'd1;
      pkt_checksum <= pkt_checksum ^ wire_flit.payload.word;
      if (q_full) begin
        overflow <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Receive queue
  // ----------------------------------------------------------
  assign q_full  = (rx_level == 3'(RXQ_DEPTH));
  assign q_push  = is_data && !q_full;
  // Popping an empty queue does nothing
  assign q_pop   = pop && (rx_level != 3'd0);
  assign rx_word = q_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rx_level <= '0;
    end else begin
      if (q_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Level changes only when exactly one side moves
      if (q_push && !q_pop) begin
        rx_level <= rx_level + 3'd1;
      end else if (q_pop && !q_push) begin
        rx_level <= rx_level - 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (q_push) begin
      q_mem[wr_ptr] <= wire_flit.payload.word;
    end
  end

endmodule

/* hdl/wire_ctrl.sv */
module wire_ctrl (
  input  logic              clk,
  input  logic              reset,
  input  wire_pkg::wb_req_t wb_req,
  output wire_pkg::wb_rsp_t wb_rsp,
  output logic              launch,
  output wire_pkg::flit_t   launch_flit,
  output logic              pop,
  input  logic [31:0]       rx_word,
  input  logic [2:0]        rx_level,
  input  logic [7:0]        pkt_tag,
  input  logic [7:0]        pkt_len,
  input  logic [7:0]        pkt_count,
  input  logic [31:0]       pkt_checksum,
  input  logic              overflow
);

  import wire_pkg::*;

  logic        req_valid;
  logic        accept;
  logic        is_tx;
  logic        is_rx_pop;
  logic        done;
  logic [31:0] status_word;
  logic [31:0] rd_mux;
  flit_t       flit_next;
  logic        ack_q;
  logic [31:0] rd_dat_q;

  // ----------------------------------------------------------
  // Request decode
  // ----------------------------------------------------------
  assign req_valid = wb_req.cyc && wb_req.stb;
  // A request is taken once and ack follows on the next edge
  // While ack is high the same request is not taken again
  assign accept    = req_valid && !ack_q;
  assign is_tx     = (wb_req.adr == ADR_TX_HDR) || (wb_req.adr == ADR_TX_DATA);
  assign is_rx_pop = !wb_req.we && (wb_req.adr == ADR_RX_DATA) && (rx_level != 3'd0);

  // The packet is done once every announced word has arrived
  assign done = (pkt_len != 8'd0) && (pkt_count == pkt_len);

  assign status_word = {8'h00, pkt_tag, pkt_count, 3'b000, done, overflow, rx_level};

  // Read data for the addressed register
  always_comb begin
    rd_mux = '0;
    case (wb_req.adr)
      ADR_RX_DATA:  rd_mux = (rx_level != 3'd0) ? rx_word : 32'h0;
      ADR_STATUS:   rd_mux = status_word;
      ADR_CHECKSUM: rd_mux = pkt_checksum;
      default:      rd_mux = '0;
    endcase
  end

  // The address picks the flit kind and the bus data is the payload
  always_comb begin
    flit_next.kind         = (wb_req.adr == ADR_TX_HDR) ? FLIT_HDR : FLIT_DATA;
    flit_next.payload.word = wb_req.dat;
  end

  // ----------------------------------------------------------
  // Control pulses
  // ----------------------------------------------------------

  // Launch and pop rise in the same cycle as ack
  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q  <= 1'b0;
      launch <= 1'b0;
      pop    <= 1'b0;
    end else begin
      ack_q  <= accept;
      launch <= accept && wb_req.we && is_tx;
      pop    <= accept && is_rx_pop;
    end
  end

  // ----------------------------------------------------------
  // Payload registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      rd_dat_q <= wb_req.we ? 32'h0 : rd_mux;
    end
    if (accept && wb_req.we && is_tx) begin
      launch_flit <= flit_next;
    end
  end

  // Read data is valid together with ack
  assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};

endmodule

/* hdl/wire_link_top.sv */
module wire_link_top #(
  parameter int NUM_STAGES = 3
) (
  input  logic              clk,
  input  logic              reset,
  input  wire_pkg::wb_req_t wb_req,
  output wire_pkg::wb_rsp_t wb_rsp
);

  import wire_pkg::*;

  // The wire carries one whole flit per stage
  localparam int WIDTH = $bits(flit_t);

  logic        launch;
  flit_t       launch_flit;
  logic        pop;
  logic        wire_in_valid_next;
  flit_t       wire_in;
  logic        wire_out_valid_next;
  flit_t       wire_out;
  logic [31:0] rx_word;
  logic [2:0]  rx_level;
  logic [7:0]  pkt_tag;
  logic [7:0]  pkt_len;
  logic [7:0]  pkt_count;
  logic [31:0] pkt_checksum;
  logic        overflow;

  // ----------------------------------------------------------
  // Host side
  // ----------------------------------------------------------
  wire_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .launch       (launch),
    .launch_flit  (launch_flit),
    .pop          (pop),
    .rx_word      (rx_word),
    .rx_level     (rx_level),
    .pkt_tag      (pkt_tag),
    .pkt_len      (pkt_len),
    .pkt_count    (pkt_count),
    .pkt_checksum (pkt_checksum),
    .overflow     (overflow)
  );

  // ----------------------------------------------------------
  // Wire path
  // ----------------------------------------------------------
  flit_launcher u_launcher (
    .clk             (clk),
    .reset           (reset),
    .launch          (launch),
    .launch_flit     (launch_flit),
    .wire_valid_next (wire_in_valid_next),
    .wire_flit       (wire_in)
  );

  // Flits in flight at once are limited only by the host write rate
  delay_valid_next #(
    .WIDTH      (WIDTH),
    .NUM_STAGES (NUM_STAGES)
  ) u_wire (
    .clk            (clk),
    .reset          (reset),
    .in_valid_next  (wire_in_valid_next),
    .in             (wire_in),
    .out_valid_next (wire_out_valid_next),
    .out            (wire_out)
  );

  flit_receiver u_receiver (
    .clk             (clk),
    .reset           (reset),
    .wire_valid_next (wire_out_valid_next),
    .wire_flit       (wire_out),
    .pop             (pop),
    .rx_word         (rx_word),
    .rx_level        (rx_level),
    .pkt_tag         (pkt_tag),
    .pkt_len         (pkt_len),
    .pkt_count       (pkt_count),
    .pkt_checksum    (pkt_checksum),
    .overflow        (overflow)
  );

endmodule

/* bench/wire_link_checker.sv */
module wire_link_checker #(
  parameter int WIDTH       = 1,
  parameter int DELAY       = 1,
  parameter bit WIRE_CHECKS = 1'b1,
  parameter bit BUS_CHECKS  = 1'b1
) (
  input logic             clk,
  input logic             reset,
  input logic             in_valid_next,
  input logic [WIDTH-1:0] in_data,
  input logic             out_valid_next,
  input logic [WIDTH-1:0] out_data,
  input logic             req_valid,
  input logic             ack
);

  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------------------------
  // Valid-next delay line
  // ----------------------------------------------------------
  // With no stages the output is the input itself
  if (WIRE_CHECKS && (DELAY > 0)) begin : gen_delay_checks
    // Valid-next comes out exactly DELAY cycles after it went in
    assert property (@(posedge clk) disable iff (reset)
      out_valid_next == $past(in_valid_next, DELAY))
      else $error("valid-next at the wire output is not delayed by %0d cycles", DELAY);

    // The data trails its valid-next by one cycle on both ends of the wire
    assert property (@(posedge clk) disable iff (reset)
      $past(out_valid_next) |-> (out_data == $past(in_data, DELAY)))
      else $error("data at the wire output is not aligned to its valid-next");
  end

  // ----------------------------------------------------------
  // Wishbone ack
  // ----------------------------------------------------------
  if (BUS_CHECKS) begin : gen_bus_checks
    assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
      else $error("Wishbone ack is high for more than one cycle");

    assert property (@(posedge clk) disable iff (reset) ack |-> req_valid)
      else $error("Wishbone ack without a request");
  end

endmodule

// Wire timing inside the delay line
bind delay_valid_next wire_link_checker #(
  .WIDTH       (WIDTH),
  .DELAY       (NUM_STAGES),
  .WIRE_CHECKS (1'b1),
  .BUS_CHECKS  (1'b0)
) u_wire_check (
  .clk            (clk),
  .reset          (reset),
  .in_valid_next  (in_valid_next),
  .in_data        (in),
  .out_valid_next (out_valid_next),
  .out_data       (out),
  .req_valid      (1'b0),
  .ack            (1'b0)
);

// Host bus handshake at the top level
bind wire_link_top wire_link_checker #(
  .WIRE_CHECKS (1'b0),
  .BUS_CHECKS  (1'b1)
) u_bus_check (
  .clk            (clk),
  .reset          (reset),
  .in_valid_next  (1'b0),
  .in_data        (1'b0),
  .out_valid_next (1'b0),
  .out_data       (1'b0),
  .req_valid      (wb_req.cyc && wb_req.stb),
  .ack            (wb_rsp.ack)
);

/* bench/wire_link_tb.sv */
module wire_link_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import wire_pkg::*;

  localparam int NUM_STAGES    = 3;
  localparam int NUM_TESTS     = 6;
  localparam int ACK_LIMIT     = 20;
  localparam int SETTLE_CYCLES = 10;

  logic        clk;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  int          error_count;
  int          tests_run;
  int          tests_failed;
  logic [15:0] lfsr_state;

  wire_link_top #(
    .NUM_STAGES (NUM_STAGES)
  ) u_wire_link_top (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #10 clk = ~clk;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  // Taps 16, 14, 13 and 11 give a maximal length sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step for every bit of the word
  task automatic rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  // Header payload: tag in the low byte, length in the next
  function automatic logic [31:0] hdr_word(input logic [7:0] tag, input logic [7:0] len);
    return {16'h0000, len, tag};
  endfunction

  // Status layout: level 2:0, overflow 3, done 4, count 15:8, tag 23:16
  function automatic logic [31:0] status_of(input logic [2:0] level, input logic ovf,
                                            input logic [7:0] count, input logic done,
                                            input logic [7:0] tag);
    return {8'h00, tag, count, 3'b000, done, ovf, level};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    error_count++;
  endtask

  // One Wishbone classic access, held until ack or until the limit runs out
  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                           output logic [31:0] rd);
    int  cycles;
    bit  got_ack;
    got_ack = 1'b0;
    cycles  = 0;
    rd      = '0;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    while (!got_ack && cycles < ACK_LIMIT) begin
      @(posedge clk);
      cycles++;
      got_ack = wb_rsp.ack;
      rd      = wb_rsp.dat;
    end
    wb_req <= '0;
    if (!got_ack) begin
      $display("No Wishbone ack within %0d cycles for address %0d at %0t ns",
               ACK_LIMIT, adr, $time);
      error_count++;
    end
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] rd);
    wb_access(1'b0, adr, 32'h0, rd);
  endtask

  // Longer than the NUM_STAGES+3 cycle write latency
  task automatic settle();
    repeat (SETTLE_CYCLES) @(posedge clk);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d mismatches", name, error_count - errs_before);
    end
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_reset_values();
    int          errs_before;
    logic [31:0] rd;
    errs_before = error_count;
    wb_read(ADR_STATUS, rd);
    if (rd !== 32'h0) report_mismatch("status", rd, 32'h0);
    wb_read(ADR_CHECKSUM, rd);
    if (rd !== 32'h0) report_mismatch("checksum", rd, 32'h0);
    // The empty queue reads as zero
    wb_read(ADR_RX_DATA, rd);
    if (rd !== 32'h0) report_mismatch("rx_data", rd, 32'h0);
    end_test("reset_values", errs_before);
  endtask

  task automatic test_short_packet();
    int          errs_before;
    logic [31:0] rd;
    logic [31:0] words [2];
    errs_before = error_count;
    words[0] = 32'h1234_5678;
    words[1] = 32'h9abc_def0;
    wb_write(ADR_TX_HDR, hdr_word(8'h5a, 8'd2));
    wb_write(ADR_TX_DATA, words[0]);
    wb_write(ADR_TX_DATA, words[1]);
    settle();
    wb_read(ADR_STATUS, rd);
    if (rd !== status_of(3'd2, 1'b0, 8'd2, 1'b1, 8'h5a))
      report_mismatch("status", rd, status_of(3'd2, 1'b0, 8'd2, 1'b1, 8'h5a));
    wb_read(ADR_CHECKSUM, rd);
    if (rd !== (words[0] ^ words[1])) report_mismatch("checksum", rd, words[0] ^ words[1]);
    for (int i = 0; i < 2; i++) begin
      wb_read(ADR_RX_DATA, rd);
      if (rd !== words[i]) report_mismatch("rx_data", rd, words[i]);
    end
    end_test("short_packet", errs_before);
  endtask

  task automatic test_burst();
    int          errs_before;
    logic [31:0] rd;
    logic [31:0] words [4];
    errs_before = error_count;
    words = '{32'hdead_0001, 32'hbeef_0002, 32'hcafe_0003, 32'hf00d_0004};
    wb_write(ADR_TX_HDR, hdr_word(8'h11, 8'd4));
    for (int i = 0; i < 4; i++) wb_write(ADR_TX_DATA, words[i]);
    settle();
    // The level is checked before every pop and once after the last
    for (int i = 0; i < 5; i++) begin
      wb_read(ADR_STATUS, rd);
      if (rd !== status_of(3'(4 - i), 1'b0, 8'd4, 1'b1, 8'h11))
        report_mismatch("status", rd, status_of(3'(4 - i), 1'b0, 8'd4, 1'b1, 8'h11));
      if (i < 4) begin
        wb_read(ADR_RX_DATA, rd);
        if (rd !== words[i]) report_mismatch("rx_data", rd, words[i]);
      end
    end
    end_test("burst", errs_before);
  endtask

  task automatic test_overflow();
    int          errs_before;
    logic [31:0] rd;
    logic [31:0] words [6];
    logic [31:0] exp_cs;
    errs_before = error_count;
    exp_cs = '0;
    wb_write(ADR_TX_HDR, hdr_word(8'h33, 8'd6));
    for (int i = 0; i < 6; i++) begin
      words[i] = 32'h4000_0000 | (i * 32'h0011_1111);
      exp_cs   = exp_cs ^ words[i];
      wb_write(ADR_TX_DATA, words[i]);
    end
    settle();
    // The last two words are dropped but still counted
    wb_read(ADR_STATUS, rd);
    if (rd !== status_of(3'd4, 1'b1, 8'd6, 1'b1, 8'h33))
      report_mismatch("status", rd, status_of(3'd4, 1'b1, 8'd6, 1'b1, 8'h33));
    wb_read(ADR_CHECKSUM, rd);
    if (rd !== exp_cs) report_mismatch("checksum", rd, exp_cs);
    for (int i = 0; i < 4; i++) begin
      wb_read(ADR_RX_DATA, rd);
      if (rd !== words[i]) report_mismatch("rx_data", rd, words[i]);
    end
    end_test("overflow", errs_before);
  endtask

  task automatic test_header_clear();
    int          errs_before;
    logic [31:0] rd;
    errs_before = error_count;
    wb_write(ADR_TX_HDR, hdr_word(8'ha7, 8'd3));
    settle();
    wb_read(ADR_STATUS, rd);
    if (rd !== status_of(3'd0, 1'b0, 8'd0, 1'b0, 8'ha7))
      report_mismatch("status", rd, status_of(3'd0, 1'b0, 8'd0, 1'b0, 8'ha7));
    wb_read(ADR_CHECKSUM, rd);
    if (rd !== 32'h0) report_mismatch("checksum", rd, 32'h0);
    end_test("header_clear", errs_before);
  endtask

  task automatic test_random_packets();
    int          errs_before;
    logic [31:0] rd;
    logic [31:0] words [4];
    logic [31:0] exp_cs;
    logic [7:0]  tag;
    errs_before = error_count;
    for (int p = 0; p < 5; p++) begin
      tag    = 8'h60 + 8'(p);
      exp_cs = '0;
      wb_write(ADR_TX_HDR, hdr_word(tag, 8'd4));
      for (int i = 0; i < 4; i++) begin
        rand_word(words[i]);
        exp_cs = exp_cs ^ words[i];
        wb_write(ADR_TX_DATA, words[i]);
      end
      settle();
      wb_read(ADR_CHECKSUM, rd);
      if (rd !== exp_cs) report_mismatch("checksum", rd, exp_cs);
      wb_read(ADR_STATUS, rd);
      if (rd !== status_of(3'd4, 1'b0, 8'd4, 1'b1, tag))
        report_mismatch("status", rd, status_of(3'd4, 1'b0, 8'd4, 1'b1, tag));
      for (int i = 0; i < 4; i++) begin
        wb_read(ADR_RX_DATA, rd);
        if (rd !== words[i]) report_mismatch("rx_data", rd, words[i]);
      end
    end
    end_test("random_packets", errs_before);
  endtask

  // ----------------------------------------------------------
  // Watchdog and main sequence
  // ----------------------------------------------------------
  initial begin
    #(NUM_TESTS * 2000);
    $display("Watchdog expired after %0d ns before the tests finished", NUM_TESTS * 2000);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    wb_req       = '0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = 16'd20960;
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    test_reset_values();
    test_short_packet();
    test_burst();
    test_overflow();
    test_header_clear();
    test_random_packets();

    $display("tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sim.f */
hdl/wire_pkg.sv
hdl/delay_valid_next.sv
hdl/flit_launcher.sv
hdl/flit_receiver.sv
hdl/wire_ctrl.sv
hdl/wire_link_top.sv
bench/wire_link_checker.sv
bench/wire_link_tb.sv

/* run.sh */
#!/bin/sh
# Builds the wire link simulation with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module wire_link_tb \
  -f sim.f \
  --Mdir obj_dir \
  -o wire_link_sim

# A failing assertion may stop the run early, so the log decides
./obj_dir/wire_link_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
